/* rtl/mult_config.svh */
`ifndef MULT_CONFIG_SVH
`define MULT_CONFIG_SVH

// operand width in bits, both A and B
`define MULT_WIDTH 8

// operand pairs buffered ahead of the core
`define MULT_FIFO_DEPTH 4

// bit counter width, log2 of MULT_WIDTH
// must be kept in step with MULT_WIDTH by hand
`define MULT_CNT_BITS 3

`endif

/* rtl/mult_data_pkg.sv */
`include "mult_config.svh"

package mult_data_pkg;

    // one signed operand, A or B
    typedef logic signed [`MULT_WIDTH-1:0] operand_t;

    // full signed product, twice the operand width
    typedef logic signed [2*`MULT_WIDTH-1:0] product_t;

endpackage

/* rtl/mult_ctrl_pkg.sv */
package mult_ctrl_pkg;

    // load, iterate, hold result
    typedef enum logic [1:0] {
        IDLE = 2'b00,
        RUN  = 2'b01,
        HOLD = 2'b10
    } mult_state_t;

endpackage

/* rtl/operand_fifo.sv */
`timescale 1ns/10ps

module operand_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr_valid,
    input  mult_data_pkg::operand_t wr_a,
    input  mult_data_pkg::operand_t wr_b,
    output logic                  wr_ready,
    output logic                  rd_valid,
    output mult_data_pkg::operand_t rd_a,
    output mult_data_pkg::operand_t rd_b,
    input  logic                  rd_ready
);

    import mult_data_pkg::*;

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);
    localparam logic [PTR_BITS-1:0] LAST_PTR   = PTR_BITS'(DEPTH - 1);
    localparam logic [CNT_BITS-1:0] FULL_COUNT = CNT_BITS'(DEPTH);

    operand_t mem_a [DEPTH];
    operand_t mem_b [DEPTH];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                do_wr;
    logic                do_rd;

    assign wr_ready = (count != FULL_COUNT);
    assign rd_valid = (count != '0);
    assign do_wr    = wr_valid & wr_ready;
    assign do_rd    = rd_valid & rd_ready;

    // head entry, no read latency
    assign rd_a = mem_a[rd_ptr];
    assign rd_b = mem_b[rd_ptr];

    always_ff @(posedge CLK)
    begin
        if (do_wr)
        begin
            mem_a[wr_ptr] <= wr_a;
            mem_b[wr_ptr] <= wr_b;
        end
    end

    always_ff @(posedge CLK or negedge RESET)
    begin
        if (!RESET)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;

            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // push and pop together
            endcase
        end
    end

endmodule

/* rtl/sequential_multiply_controller.sv */
`timescale 1ns/10ps

module sequential_multiply_controller (
    input  logic CLK,
    input  logic RESET,
    input  logic src_valid,
    input  logic dst_ready,
    input  logic b_val,
    input  logic stop,
    output logic en_A,
    output logic en_B,
    output logic sign_sel,
    output logic a_sel,
    output logic count_en,
    output logic clear,
    output logic prod_clear,
    output logic en_prod,
    output logic src_ready,
    output logic dst_valid
);

    import mult_ctrl_pkg::*;

    mult_state_t c_state;
    mult_state_t n_state;

    always_ff @(posedge CLK or negedge RESET)
    begin
        if (!RESET)
            c_state <= IDLE;
        else
            c_state <= n_state;
    end

    always_comb
    begin
        case (c_state)
            IDLE:
            begin
                if (src_valid)
                    n_state = RUN;
                else
                    n_state = IDLE;
            end
            RUN:
            begin
                if (stop & !dst_ready)
                    n_state = HOLD;       // consumer not ready yet
                else if (stop & dst_ready)
                    n_state = IDLE;
                else
                    n_state = RUN;
            end
            HOLD:
            begin
                if (dst_ready)
                    n_state = IDLE;
                else
                    n_state = HOLD;
            end
            default: n_state = IDLE;
        endcase
    end

    always_comb
    begin
        case (c_state)
            IDLE:
            begin
                if (src_valid)
                begin
                    // take the pair at the FIFO head
                    en_A       = 1'b1;
                    en_B       = 1'b1;
                    prod_clear = 1'b1;
                end
                else
                begin
                    en_A       = 1'b0;
                    en_B       = 1'b0;
                    prod_clear = 1'b0;
                end
                sign_sel  = 1'b0;
                a_sel     = 1'b0;
                count_en  = 1'b0;
                clear     = 1'b0;
                en_prod   = 1'b0;
                src_ready = 1'b1;
                dst_valid = 1'b0;
            end
            RUN:
            begin
                if (stop)
                begin
                    // msb of B has negative weight
                    en_A       = 1'b0;
                    en_B       = 1'b0;
                    sign_sel   = 1'b1;
                    a_sel      = b_val;
                    count_en   = 1'b0;
                    clear      = 1'b1;
                    prod_clear = 1'b0;
                    en_prod    = 1'b1;
                end
                else
                begin
                    en_A       = 1'b0;
                    en_B       = 1'b0;
                    sign_sel   = 1'b0;
                    a_sel      = b_val;   // add A only on a set bit
                    count_en   = 1'b1;
                    clear      = 1'b0;
                    prod_clear = 1'b0;
                    en_prod    = 1'b1;
                end
                src_ready = 1'b0;
                dst_valid = stop;         // product complete this cycle
            end
            HOLD:
            begin
                en_A       = 1'b0;
                en_B       = 1'b0;
                sign_sel   = 1'b0;
                a_sel      = 1'b0;
                count_en   = 1'b0;
                clear      = 1'b0;
                prod_clear = 1'b0;
                en_prod    = 1'b0;
                src_ready  = 1'b0;
                dst_valid  = 1'b1;
            end
            default:
            begin
                en_A       = 1'b0;
                en_B       = 1'b0;
                sign_sel   = 1'b0;
                a_sel      = 1'b0;
                count_en   = 1'b0;
                clear      = 1'b0;
                prod_clear = 1'b0;
                en_prod    = 1'b0;
                src_ready  = 1'b0;
                dst_valid  = 1'b0;
            end
        endcase
    end

endmodule

/* rtl/seq_mult_datapath.sv */
`timescale 1ns/10ps
`include "mult_config.svh"

module seq_mult_datapath (
    input  logic                    CLK,
    input  logic                    RESET,
    input  mult_data_pkg::operand_t load_a,
    input  mult_data_pkg::operand_t load_b,
    input  logic                    en_A,
    input  logic                    en_B,
    input  logic                    sign_sel,
    input  logic                    a_sel,
    input  logic                    count_en,
    input  logic                    clear,
    input  logic                    prod_clear,
    input  logic                    en_prod,
    output logic                    b_val,
    output logic                    stop,
    output mult_data_pkg::product_t result
);

    import mult_data_pkg::*;

    localparam int LAST_COUNT = `MULT_WIDTH - 1;

    operand_t reg_a;
    operand_t reg_b;
    product_t acc;
    product_t a_ext;
    product_t shifted;
    product_t addend;
    product_t acc_next;

    logic [`MULT_CNT_BITS-1:0] count;

    always_ff @(posedge CLK)
    begin
        if (en_A)
            reg_a <= load_a;
        if (en_B)
            reg_b <= load_b;
    end

    always_ff @(posedge CLK or negedge RESET)
    begin
        if (!RESET)
            count <= '0;
        else if (clear)
            count <= '0;
        else if (count_en)
            count <= count + 1'b1;
    end

    assign b_val = reg_b[count];  // current multiplier bit
    assign stop  = (count == LAST_COUNT[`MULT_CNT_BITS-1:0]);

    // partial product for this bit position
    assign a_ext    = product_t'(reg_a);  // sign extends
    assign shifted  = a_ext <<< count;
    assign addend   = !a_sel ? '0 : (sign_sel ? -shifted : shifted);
    assign acc_next = acc + addend;

    always_ff @(posedge CLK)
    begin
        if (prod_clear)
            acc <= '0;
        else if (en_prod)
            acc <= acc_next;
    end

    // valid in the stop cycle as well as in HOLD
    assign result = en_prod ? acc_next : acc;

endmodule

/* rtl/mult_unit.sv */
`timescale 1ns/10ps
`include "mult_config.svh"

module mult_unit (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    in_valid,
    input  mult_data_pkg::operand_t in_a,
    input  mult_data_pkg::operand_t in_b,
    output logic                    in_ready,
    output logic                    out_valid,
    output mult_data_pkg::product_t out_product,
    input  logic                    out_ready
);

    import mult_data_pkg::*;

    // FIFO head towards the core
    logic     src_valid;
    logic     src_ready;
    operand_t head_a;
    operand_t head_b;

    // controller to datapath
    logic en_A;
    logic en_B;
    logic sign_sel;
    logic a_sel;
    logic count_en;
    logic clear;
    logic prod_clear;
    logic en_prod;
    logic b_val;
    logic stop;

    operand_fifo #(
        .DEPTH (`MULT_FIFO_DEPTH)
    ) i_operand_fifo (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr_valid (in_valid),
        .wr_a     (in_a),
        .wr_b     (in_b),
        .wr_ready (in_ready),
        .rd_valid (src_valid),
        .rd_a     (head_a),
        .rd_b     (head_b),
        .rd_ready (src_ready)
    );

    sequential_multiply_controller i_controller (
        .CLK        (CLK),
        .RESET      (RESET),
        .src_valid  (src_valid),
        .dst_ready  (out_ready),
        .b_val      (b_val),
        .stop       (stop),
        .en_A       (en_A),
        .en_B       (en_B),
        .sign_sel   (sign_sel),
        .a_sel      (a_sel),
        .count_en   (count_en),
        .clear      (clear),
        .prod_clear (prod_clear),
        .en_prod    (en_prod),
        .src_ready  (src_ready),
        .dst_valid  (out_valid)
    );

    seq_mult_datapath i_datapath (
        .CLK        (CLK),
        .RESET      (RESET),
        .load_a     (head_a),
        .load_b     (head_b),
        .en_A       (en_A),
        .en_B       (en_B),
        .sign_sel   (sign_sel),
        .a_sel      (a_sel),
        .count_en   (count_en),
        .clear      (clear),
        .prod_clear (prod_clear),
        .en_prod    (en_prod),
        .b_val      (b_val),
        .stop       (stop),
        .result     (out_product)
    );

endmodule

/* test/tb_mult_unit.sv */
`timescale 1ns/10ps
`include "mult_config.svh"

module tb_mult_unit;

    import mult_data_pkg::*;

    localparam int WAIT_LIMIT   = 2000;
    localparam int RANDOM_PAIRS = 300;
    localparam int READY_RANDOM = 0;
    localparam int READY_HIGH   = 1;
    localparam int READY_LOW    = 2;

    logic     CLK;
    logic     RESET;
    logic     in_valid;
    operand_t in_a;
    operand_t in_b;
    logic     in_ready;
    logic     out_valid;
    product_t out_product;
    logic     out_ready;

    product_t expected_q[$];   // products of accepted pairs, oldest first
    int       errors;
    int       timeouts;
    int       accepted;
    int       delivered;
    int       ready_mode;
    logic     held_valid;
    product_t held_product;
    operand_t corners[5];
    operand_t most_neg;
    int       edges;
    int       queued;
    int       wait_cycles;
    logic     took;

    mult_unit i_mult_unit (
        .CLK         (CLK),
        .RESET       (RESET),
        .in_valid    (in_valid),
        .in_a        (in_a),
        .in_b        (in_b),
        .in_ready    (in_ready),
        .out_valid   (out_valid),
        .out_product (out_product),
        .out_ready   (out_ready)
    );

    always #2 CLK = ~CLK;

    // consumer side ready pattern
    always @(posedge CLK)
    begin
        case (ready_mode)
            READY_HIGH: out_ready <= 1'b1;
            READY_LOW:  out_ready <= 1'b0;
            default:    out_ready <= ($urandom_range(0, 99) < 60);
        endcase
    end

    // reference model, two's complement product of sign-extended operands
    function automatic product_t signed_product(input operand_t a, input operand_t b);
        product_t wide_a;
        product_t wide_b;
        wide_a = product_t'(a);
        wide_b = product_t'(b);
        return wide_a * wide_b;
    endfunction

    task automatic check_value(input logic signed [63:0] expected,
                               input logic signed [63:0] actual,
                               input string what);
        if (actual !== expected)
        begin
            $display("Mismatch at %0t ns: %s, expected %0d, got %0d",
                     $time, what, expected, actual);
            errors++;
        end
    endtask

    // handshakes sampled mid-cycle, they complete on the next rising edge
    always @(negedge CLK)
    begin
        if (RESET)
        begin
            if (held_valid)
            begin
                check_value(1, 64'(out_valid), "out_valid dropped while stalled");
                check_value(64'(held_product), 64'(out_product),
                            "out_product moved while stalled");
            end
            held_valid   = out_valid & !out_ready;
            held_product = out_product;
            if (in_valid && in_ready)
            begin
                expected_q.push_back(signed_product(in_a, in_b));
                accepted++;
            end
            if (out_valid && out_ready)
            begin
                if (expected_q.size() == 0)
                begin
                    $display("Product %0d delivered at %0t ns with no pair pending",
                             out_product, $time);
                    errors++;
                end
                else
                    check_value(64'(expected_q.pop_front()), 64'(out_product), "product");
                delivered++;
            end
        end
    end

    // called right after a rising edge, returns right after the write edge
    task automatic send_pair(input operand_t a, input operand_t b);
        in_valid <= 1'b1;
        in_a     <= a;
        in_b     <= b;
        wait_cycles = 0;
        @(negedge CLK);
        while (!in_ready && wait_cycles < WAIT_LIMIT)
        begin
            @(negedge CLK);
            wait_cycles++;
        end
        if (!in_ready)
        begin
            $display("Timeout at %0t ns: in_ready never rose for a new pair", $time);
            timeouts++;
        end
        @(posedge CLK);
    endtask

    // one attempt only, took tells whether the edge wrote the pair
    task automatic try_pair(input operand_t a, input operand_t b);
        in_valid <= 1'b1;
        in_a     <= a;
        in_b     <= b;
        @(negedge CLK);
        took = in_ready;
        @(posedge CLK);
    endtask

    task automatic idle_cycles(input int n);
        in_valid <= 1'b0;
        repeat (n) @(posedge CLK);
    endtask

    task automatic set_ready_mode(input int mode);
        @(negedge CLK);
        ready_mode = mode;
        @(posedge CLK);
    endtask

    task automatic wait_for_drain();
        wait_cycles = 0;
        @(posedge CLK);
        while (expected_q.size() != 0 && wait_cycles < WAIT_LIMIT)
        begin
            @(posedge CLK);
            wait_cycles++;
        end
        if (expected_q.size() != 0)
        begin
            $display("Timeout at %0t ns: %0d products never came out", $time, expected_q.size());
            timeouts++;
        end
    endtask

    initial
    begin
        void'($urandom(32'h8592));
        CLK        = 1'b0;
        RESET      = 1'b0;
        in_valid   = 1'b0;
        in_a       = '0;
        in_b       = '0;
        out_ready  = 1'b0;
        ready_mode = READY_LOW;
        held_valid = 1'b0;
        errors     = 0;
        timeouts   = 0;
        accepted   = 0;
        delivered  = 0;
        most_neg   = '0;
        most_neg[`MULT_WIDTH-1] = 1'b1;
        corners[0] = most_neg;
        corners[1] = '1;           // -1
        corners[2] = '0;
        corners[3] = ~most_neg;    // most positive
        corners[4] = operand_t'(1);

        repeat (10) @(posedge CLK);
        RESET <= 1'b1;
        @(negedge CLK);
        check_value(0, 64'(out_valid), "out_valid after reset");
        check_value(1, 64'(in_ready), "in_ready after reset");

        // latency from a single write into an idle unit
        set_ready_mode(READY_HIGH);
        send_pair(operand_t'($urandom), operand_t'($urandom));
        in_valid <= 1'b0;
        edges = 0;
        @(negedge CLK);
        while (!out_valid && edges < WAIT_LIMIT)
        begin
            @(negedge CLK);
            edges++;
        end
        if (!out_valid)
        begin
            $display("Timeout at %0t ns: out_valid never rose after a single write", $time);
            timeouts++;
        end
        check_value(`MULT_WIDTH + 1, 64'(edges + 1), "edges from write to product delivery");
        wait_for_drain();

        set_ready_mode(READY_RANDOM);
        foreach (corners[i])
            foreach (corners[j])
            begin
                send_pair(corners[i], corners[j]);
                idle_cycles($urandom_range(0, 2));
            end
        wait_for_drain();

        for (int n = 0; n < RANDOM_PAIRS; n++)
        begin
            send_pair(operand_t'($urandom), operand_t'($urandom));
            if ($urandom_range(0, 1) == 1)
                idle_cycles($urandom_range(1, 4));
        end
        idle_cycles(0);
        wait_for_drain();

        // back-pressure: stall the result and fill the FIFO behind it
        set_ready_mode(READY_LOW);
        send_pair(operand_t'($urandom), operand_t'($urandom));
        queued = 0;
        took   = 1'b1;
        while (took && queued <= `MULT_FIFO_DEPTH)
        begin
            try_pair(operand_t'($urandom), operand_t'($urandom));
            if (took)
                queued++;
        end
        check_value(`MULT_FIFO_DEPTH, 64'(queued), "pairs queued behind a held result");
        repeat (2 * `MULT_WIDTH)
        begin
            try_pair(operand_t'($urandom), operand_t'($urandom));
            check_value(0, 64'(took), "pair written into a full FIFO");
        end
        idle_cycles(1);
        check_value(`MULT_FIFO_DEPTH + 1, 64'(expected_q.size()),
                    "products pending while stalled");
        set_ready_mode(READY_RANDOM);
        wait_for_drain();

        check_value(64'(accepted), 64'(delivered),
                    "products delivered against pairs accepted");
        $display("Closing: %0d pairs, %0d products, %0d errors, %0d timeouts",
                 accepted, delivered, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

/* build.f */
+incdir+rtl
rtl/mult_data_pkg.sv
rtl/mult_ctrl_pkg.sv
rtl/operand_fifo.sv
rtl/sequential_multiply_controller.sv
rtl/seq_mult_datapath.sv
rtl/mult_unit.sv
test/tb_mult_unit.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -j 0
TOP       ?= tb_mult_unit
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Done: no errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
